//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_game_ctrl -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

//--- design/game_ctrl_top.sv
// top level of the game control core with register block, key decoder, game FSM and scores
`timescale 1ns/1ps

module game_ctrl_top
#(
	parameter int NUM_MAPS = 4
)
(
	input  logic                    Clk,
	input  logic                    rst_n,
	input  game_pkg::axi_lite_req_t axi_req,
	output game_pkg::axi_lite_rsp_t axi_rsp,
	input  logic                    blue_win,
	input  logic                    red_win,
	output logic [2:0]              background_sel,
	output logic                    load_background,
	output game_pkg::game_state_e   game_state
);

	logic [7:0]              keycode;
	logic                    reset_game;
	logic                    reset_round;
	logic [7:0]              blue_score;
	logic [7:0]              red_score;
	game_pkg::key_evt_t      key_evt;
	game_pkg::game_status_t  status;
	game_pkg::round_result_t result;

	game_regs regs_i
	(
		.Clk         (Clk),
		.rst_n       (rst_n),
		.axi_req     (axi_req),
		.axi_rsp     (axi_rsp),
		.keycode     (keycode),
		.reset_game  (reset_game),
		.reset_round (reset_round),
		.status      (status),
		.blue_score  (blue_score),
		.red_score   (red_score)
	);

	key_decode key_decode_i
	(
		.Clk     (Clk),
		.rst_n   (rst_n),
		.keycode (keycode),
		.key_evt (key_evt)
	);

	game_state #(.NUM_MAPS(NUM_MAPS)) game_state_i
	(
		.Clk             (Clk),
		.rst_n           (rst_n),
		.key_evt         (key_evt),
		.blue_win        (blue_win),
		.red_win         (red_win),
		.reset_game      (reset_game),
		.reset_round     (reset_round),
		.status          (status),
		.load_background (load_background),
		.result          (result)
	);

	score_keeper score_keeper_i
	(
		.Clk        (Clk),
		.rst_n      (rst_n),
		.result     (result),
		.reset_game (reset_game),
		.blue_score (blue_score),
		.red_score  (red_score)
	);

	// video side sees the same code that the host reads
	assign background_sel = status.bg_sel;
	assign game_state     = status.state;

endmodule

//--- design/game_pkg.sv
// game state and key enums, keycodes, background codes, response codes, bus and status structs
package game_pkg;

	// game flow states
	typedef enum logic [2:0]
	{
		ST_MENU,
		ST_ROUND_PAUSED,
		ST_ROUND_RUN,
		ST_BLUE_WINS,
		ST_RED_WINS
	} game_state_e;

	// decoded key commands
	typedef enum logic [1:0]
	{
		KEY_NONE,
		KEY_START,
		KEY_MAP_UP,
		KEY_MAP_DOWN
	} key_cmd_e;

	// usb hid keycodes
	localparam logic [7:0] KC_ENTER = 8'h28;
	localparam logic [7:0] KC_W     = 8'h1a;
	localparam logic [7:0] KC_UP    = 8'h52;
	localparam logic [7:0] KC_S     = 8'h16;
	localparam logic [7:0] KC_DOWN  = 8'h51;

	// background codes around the maps at 1..NUM_MAPS
	localparam logic [2:0] BG_MENU        = 3'd0;
	localparam logic [2:0] BG_BLUE_SCREEN = 3'd6;
	localparam logic [2:0] BG_RED_SCREEN  = 3'd7;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed
	{
		logic     valid;
		key_cmd_e cmd;
	} key_evt_t;

	// winner 0 is blue, 1 is red
	typedef struct packed
	{
		logic valid;
		logic winner;
	} round_result_t;

	typedef struct packed
	{
		game_state_e state;
		logic [2:0]  bg_sel;
		logic [2:0]  map;
	} game_status_t;

	// master side of the axi4-lite bus
	typedef struct packed
	{
		logic        awvalid;
		logic [7:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [7:0]  araddr;
		logic        rready;
	} axi_lite_req_t;

	// slave side of the axi4-lite bus
	typedef struct packed
	{
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axi_lite_rsp_t;

endpackage

//--- design/game_regs.sv
// axi4-lite register block with keycode, control pulses, status and score readback
`timescale 1ns/1ps
`include "game_regmap.svh"

module game_regs
(
	input  logic                    Clk,
	input  logic                    rst_n,
	input  game_pkg::axi_lite_req_t axi_req,
	output game_pkg::axi_lite_rsp_t axi_rsp,
	output logic [7:0]              keycode,
	output logic                    reset_game,
	output logic                    reset_round,
	input  game_pkg::game_status_t  status,
	input  logic [7:0]              blue_score,
	input  logic [7:0]              red_score
);

	logic        bvalid_q;
	logic [1:0]  bresp_q;
	logic        rvalid_q;
	logic [31:0] rdata_q;
	logic [1:0]  rresp_q;
	logic [7:0]  keycode_q;

	logic        wr_accept;
	logic        rd_accept;
	logic        wr_err;
	logic        rd_err;
	logic [31:0] rd_data;

	// address and data are taken together with one outstanding response
	assign wr_accept = axi_req.awvalid && axi_req.wvalid && !bvalid_q;
	assign rd_accept = axi_req.arvalid && !rvalid_q;

	// writes to status and score are ignored but still okay
	always_comb
	begin
		case (axi_req.awaddr)
			`REG_KEYCODE,
			`REG_CONTROL,
			`REG_STATUS,
			`REG_SCORE: wr_err = 1'b0;
			default:    wr_err = 1'b1;
		endcase
	end

	// read mux over live inputs
	always_comb
	begin
		rd_err  = 1'b0;
		rd_data = '0;
		case (axi_req.araddr)
			`REG_KEYCODE: rd_data = {24'b0, keycode_q};
			`REG_CONTROL: rd_data = '0;
			`REG_STATUS:  rd_data = {21'b0, status.map, 1'b0, status.bg_sel, 1'b0, status.state};
			`REG_SCORE:   rd_data = {16'b0, red_score, blue_score};
			default:      rd_err  = 1'b1;
		endcase
	end

	// write channel and registers
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			bvalid_q    <= 1'b0;
			keycode_q   <= '0;
			reset_game  <= 1'b0;
			reset_round <= 1'b0;
		end
		else
		begin
			// control bits only live for one cycle
			reset_game  <= 1'b0;
			reset_round <= 1'b0;
			if (wr_accept)
			begin
				bvalid_q <= 1'b1;
				if (axi_req.awaddr == `REG_KEYCODE && axi_req.wstrb[0])
					keycode_q <= axi_req.wdata[7:0];
				if (axi_req.awaddr == `REG_CONTROL)
				begin
					reset_game  <= axi_req.wdata[`CTRL_RESET_GAME];
					reset_round <= axi_req.wdata[`CTRL_RESET_ROUND];
				end
			end
			else if (axi_req.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (wr_accept)
			bresp_q <= wr_err ? game_pkg::RESP_SLVERR : game_pkg::RESP_OKAY;
	end

	// read channel samples data at acceptance
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
			rvalid_q <= 1'b0;
		else if (rd_accept)
			rvalid_q <= 1'b1;
		else if (axi_req.rready)
			rvalid_q <= 1'b0;
	end

	always_ff @(posedge Clk)
	begin
		if (rd_accept)
		begin
			rdata_q <= rd_data;
			rresp_q <= rd_err ? game_pkg::RESP_SLVERR : game_pkg::RESP_OKAY;
		end
	end

	always_comb
	begin
		axi_rsp.awready = wr_accept;
		axi_rsp.wready  = wr_accept;
		axi_rsp.bvalid  = bvalid_q;
		axi_rsp.bresp   = bresp_q;
		axi_rsp.arready = !rvalid_q;
		axi_rsp.rvalid  = rvalid_q;
		axi_rsp.rdata   = rdata_q;
		axi_rsp.rresp   = rresp_q;
	end

	assign keycode = keycode_q;

endmodule

//--- design/game_state.sv
// game flow FSM with map selection, background code and load pulse
`timescale 1ns/1ps

module game_state
#(
	parameter int NUM_MAPS = 4
)
(
	input  logic                    Clk,
	input  logic                    rst_n,
	input  game_pkg::key_evt_t      key_evt,
	input  logic                    blue_win,
	input  logic                    red_win,
	input  logic                    reset_game,
	input  logic                    reset_round,
	output game_pkg::game_status_t  status,
	output logic                    load_background,
	output game_pkg::round_result_t result
);

	localparam logic [2:0] MAP_MAX = 3'(NUM_MAPS);

	game_pkg::game_state_e   state_q, state_d;
	logic [2:0]              map_q, map_d;
	logic [2:0]              bg_q, bg_d;
	game_pkg::round_result_t result_d;

	logic key_start;
	logic key_up;
	logic key_down;

	assign key_start = key_evt.valid && (key_evt.cmd == game_pkg::KEY_START);
	assign key_up    = key_evt.valid && (key_evt.cmd == game_pkg::KEY_MAP_UP);
	assign key_down  = key_evt.valid && (key_evt.cmd == game_pkg::KEY_MAP_DOWN);

	always_comb
	begin
		state_d  = state_q;
		map_d    = map_q;
		result_d = '0;
		if (reset_game)
		begin
			state_d = game_pkg::ST_MENU;
			map_d   = 3'd1;
		end
		else
		begin
			case (state_q)
				game_pkg::ST_MENU:
				begin
					if (key_start)
						state_d = game_pkg::ST_ROUND_PAUSED;
					else if (key_up && map_q < MAP_MAX)
						map_d = map_q + 3'd1;
					else if (key_down && map_q > 3'd1)
						map_d = map_q - 3'd1;
				end
				game_pkg::ST_ROUND_PAUSED:
				begin
					if (key_start)
						state_d = game_pkg::ST_ROUND_RUN;
				end
				game_pkg::ST_ROUND_RUN:
				begin
					// blue wins a tie
					if (blue_win)
					begin
						state_d         = game_pkg::ST_BLUE_WINS;
						result_d.valid  = 1'b1;
						result_d.winner = 1'b0;
					end
					else if (red_win)
					begin
						state_d         = game_pkg::ST_RED_WINS;
						result_d.valid  = 1'b1;
						result_d.winner = 1'b1;
					end
					else if (reset_round)
						state_d = game_pkg::ST_ROUND_PAUSED;
				end
				game_pkg::ST_BLUE_WINS,
				game_pkg::ST_RED_WINS:
				begin
					if (key_start)
						state_d = game_pkg::ST_MENU;
				end
				default: state_d = game_pkg::ST_MENU;
			endcase
		end
	end

	// background follows the next state
	always_comb
	begin
		case (state_d)
			game_pkg::ST_ROUND_PAUSED,
			game_pkg::ST_ROUND_RUN:    bg_d = map_d;
			game_pkg::ST_BLUE_WINS:    bg_d = game_pkg::BG_BLUE_SCREEN;
			game_pkg::ST_RED_WINS:     bg_d = game_pkg::BG_RED_SCREEN;
			default:                   bg_d = game_pkg::BG_MENU;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			state_q         <= game_pkg::ST_MENU;
			map_q           <= 3'd1;
			bg_q            <= game_pkg::BG_MENU;
			load_background <= 1'b0;
			result          <= '0;
		end
		else
		begin
			state_q         <= state_d;
			map_q           <= map_d;
			bg_q            <= bg_d;
			load_background <= (bg_d != bg_q);
			result          <= result_d;
		end
	end

	assign status = '{state: state_q, bg_sel: bg_q, map: map_q};

endmodule

//--- design/key_decode.sv
// keydown detection and keycode to key command translation
`timescale 1ns/1ps

module key_decode
(
	input  logic               Clk,
	input  logic               rst_n,
	input  logic [7:0]         keycode,
	output game_pkg::key_evt_t key_evt
);

	logic [7:0]         prev_code;
	game_pkg::key_cmd_e cmd;

	// w and up share a command, as do s and down
	always_comb
	begin
		case (keycode)
			game_pkg::KC_ENTER: cmd = game_pkg::KEY_START;
			game_pkg::KC_W,
			game_pkg::KC_UP:    cmd = game_pkg::KEY_MAP_UP;
			game_pkg::KC_S,
			game_pkg::KC_DOWN:  cmd = game_pkg::KEY_MAP_DOWN;
			default:            cmd = game_pkg::KEY_NONE;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			prev_code     <= '0;
			key_evt.valid <= 1'b0;
			key_evt.cmd   <= game_pkg::KEY_NONE;
		end
		else
		begin
			prev_code <= keycode;
			// only a change into a known code is a press
			key_evt.valid <= (keycode != prev_code) && (cmd != game_pkg::KEY_NONE);
			key_evt.cmd   <= cmd;
		end
	end

endmodule

//--- design/score_keeper.sv
// per-player round win counters with saturation
`timescale 1ns/1ps

module score_keeper
(
	input  logic                    Clk,
	input  logic                    rst_n,
	input  game_pkg::round_result_t result,
	input  logic                    reset_game,
	output logic [7:0]              blue_score,
	output logic [7:0]              red_score
);

	// stops at 255
	function automatic logic [7:0] sat_inc(input logic [7:0] value);
		if (value == 8'hff)
			return value;
		else
			return value + 8'd1;
	endfunction

	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			blue_score <= '0;
			red_score  <= '0;
		end
		else if (reset_game)
		begin
			// new game starts from zero
			blue_score <= '0;
			red_score  <= '0;
		end
		else if (result.valid)
		begin
			if (result.winner)
				red_score <= sat_inc(red_score);
			else
				blue_score <= sat_inc(blue_score);
		end
	end

endmodule

//--- include/game_regmap.svh
// register offsets of the game control block
`ifndef GAME_REGMAP_SVH
`define GAME_REGMAP_SVH

// keycode, read/write, 8 bits
`define REG_KEYCODE 8'h00

// bit 0 reset_game, bit 1 reset_round, self-clearing
`define REG_CONTROL 8'h04

// state [2:0], bg_sel [6:4], map [10:8]
`define REG_STATUS  8'h08

// blue [7:0], red [15:8]
`define REG_SCORE   8'h0c

`define CTRL_RESET_GAME  0
`define CTRL_RESET_ROUND 1

`endif

//--- list.f
+incdir+include
design/game_pkg.sv
design/game_regs.sv
design/key_decode.sv
design/game_state.sv
design/score_keeper.sv
design/game_ctrl_top.sv
verif/clk_gen.sv
verif/tb_game_ctrl.sv

//--- verif/clk_gen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps

module clk_gen
#(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 5
)
(
	output logic Clk,
	output logic rst_n
);

	initial
	begin
		Clk = 1'b0;
		forever #(PERIOD_NS / 2) Clk = ~Clk;
	end

	// release on a falling edge, away from the sampling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clk);
		@(negedge Clk);
		rst_n = 1'b1;
	end

endmodule

//--- verif/tb_game_ctrl.sv
// game control core testbench with bus tasks, reference model, checks, watchdog and report
`timescale 1ns/1ps
`include "game_regmap.svh"

module tb_game_ctrl;

	localparam int NUM_MAPS     = 4;
	localparam int RESET_CYCLES = 5;
	localparam int MAP_STEPS    = 40;
	// decoder and FSM each add one stage after the keycode write
	localparam int PIPE_STAGES  = 2;
	// upper bound on bus transactions over all tests
	localparam int TOTAL_TRANSACTIONS = 12 + 2 * MAP_STEPS + 60;
	localparam int CYCLES_PER_TRANSACTION = 20;

	logic                    Clk;
	logic                    rst_n;
	game_pkg::axi_lite_req_t axi_req;
	game_pkg::axi_lite_rsp_t axi_rsp;
	logic                    blue_win;
	logic                    red_win;
	logic [2:0]              background_sel;
	logic                    load_background;
	game_pkg::game_state_e   state_out;

	int    errors;
	int    checks;
	int    checks_at_start;
	int    errors_at_start;
	int    tests_run;
	string cur_test;

	// reference model
	game_pkg::game_state_e m_state;
	logic [2:0]            m_map;
	logic [2:0]            m_bg;
	logic [7:0]            m_blue;
	logic [7:0]            m_red;
	logic [7:0]            m_code;
	int                    m_bg_changes;

	logic        load_prev;
	logic        count_loads;
	int          load_count;
	logic [31:0] rng;

	clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i
	(
		.Clk   (Clk),
		.rst_n (rst_n)
	);

	game_ctrl_top #(.NUM_MAPS(NUM_MAPS)) dut_i
	(
		.Clk             (Clk),
		.rst_n           (rst_n),
		.axi_req         (axi_req),
		.axi_rsp         (axi_rsp),
		.blue_win        (blue_win),
		.red_win         (red_win),
		.background_sel  (background_sel),
		.load_background (load_background),
		.game_state      (state_out)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act == exp)
		else
		begin
			errors++;
			$display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	function automatic logic [2:0] background_for(input game_pkg::game_state_e st,
		input logic [2:0] map);
		case (st)
			game_pkg::ST_ROUND_PAUSED,
			game_pkg::ST_ROUND_RUN:    return map;
			game_pkg::ST_BLUE_WINS:    return game_pkg::BG_BLUE_SCREEN;
			game_pkg::ST_RED_WINS:     return game_pkg::BG_RED_SCREEN;
			default:                   return game_pkg::BG_MENU;
		endcase
	endfunction

	task automatic model_move(input game_pkg::game_state_e st, input logic [2:0] map);
		logic [2:0] bg;
		bg = background_for(st, map);
		if (bg != m_bg)
			m_bg_changes++;
		m_state = st;
		m_map   = map;
		m_bg    = bg;
	endtask

	// a press is a change of the keycode into a known code
	task automatic model_key(input logic [7:0] code);
		logic changed;
		changed = (code != m_code);
		m_code  = code;
		if (changed && code == game_pkg::KC_ENTER)
		begin
			if (m_state == game_pkg::ST_MENU)
				model_move(game_pkg::ST_ROUND_PAUSED, m_map);
			else if (m_state == game_pkg::ST_ROUND_PAUSED)
				model_move(game_pkg::ST_ROUND_RUN, m_map);
			else if (m_state == game_pkg::ST_BLUE_WINS || m_state == game_pkg::ST_RED_WINS)
				model_move(game_pkg::ST_MENU, m_map);
		end
		else if (changed && m_state == game_pkg::ST_MENU)
		begin
			if ((code == game_pkg::KC_W || code == game_pkg::KC_UP) && m_map < 3'(NUM_MAPS))
				model_move(m_state, m_map + 3'd1);
			else if ((code == game_pkg::KC_S || code == game_pkg::KC_DOWN) && m_map > 3'd1)
				model_move(m_state, m_map - 3'd1);
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] exp_resp);
		@(negedge Clk);
		axi_req.awvalid = 1'b1;
		axi_req.awaddr  = addr;
		axi_req.wvalid  = 1'b1;
		axi_req.wdata   = data;
		axi_req.wstrb   = strb;
		axi_req.bready  = 1'b1;
		@(negedge Clk);
		while (!axi_rsp.bvalid)
			@(negedge Clk);
		axi_req.awvalid = 1'b0;
		axi_req.wvalid  = 1'b0;
		check_value("bresp", {30'b0, exp_resp}, {30'b0, axi_rsp.bresp});
	endtask

	task automatic axi_read(input logic [7:0] addr, input logic [1:0] exp_resp,
		output logic [31:0] data);
		@(negedge Clk);
		axi_req.arvalid = 1'b1;
		axi_req.araddr  = addr;
		axi_req.rready  = 1'b1;
		@(negedge Clk);
		while (!axi_rsp.rvalid)
			@(negedge Clk);
		axi_req.arvalid = 1'b0;
		data = axi_rsp.rdata;
		check_value("rresp", {30'b0, exp_resp}, {30'b0, axi_rsp.rresp});
	endtask

	task automatic write_key(input logic [7:0] code);
		axi_write(`REG_KEYCODE, {24'b0, code}, 4'hf, game_pkg::RESP_OKAY);
		model_key(code);
		repeat (PIPE_STAGES) @(negedge Clk);
	endtask

	// press and release
	task automatic tap_key(input logic [7:0] code);
		write_key(code);
		write_key(8'h00);
	endtask

	task automatic enter_round();
		tap_key(game_pkg::KC_ENTER);
		tap_key(game_pkg::KC_ENTER);
	endtask

	task automatic pulse_control(input logic game, input logic round);
		axi_write(`REG_CONTROL, {30'b0, round, game}, 4'hf, game_pkg::RESP_OKAY);
		if (game)
		begin
			model_move(game_pkg::ST_MENU, 3'd1);
			m_blue = '0;
			m_red  = '0;
		end
		else if (round && m_state == game_pkg::ST_ROUND_RUN)
			model_move(game_pkg::ST_ROUND_PAUSED, m_map);
		repeat (PIPE_STAGES) @(negedge Clk);
	endtask

	// blue takes a tie and scores move one edge after the state
	task automatic raise_win(input logic blue, input logic red);
		@(negedge Clk);
		blue_win = blue;
		red_win  = red;
		@(negedge Clk);
		blue_win = 1'b0;
		red_win  = 1'b0;
		if (m_state == game_pkg::ST_ROUND_RUN && blue)
		begin
			model_move(game_pkg::ST_BLUE_WINS, m_map);
			if (m_blue != 8'hff)
				m_blue++;
		end
		else if (m_state == game_pkg::ST_ROUND_RUN && red)
		begin
			model_move(game_pkg::ST_RED_WINS, m_map);
			if (m_red != 8'hff)
				m_red++;
		end
		repeat (PIPE_STAGES) @(negedge Clk);
	endtask

	task automatic check_status();
		logic [31:0] data;
		axi_read(`REG_STATUS, game_pkg::RESP_OKAY, data);
		check_value("state", {29'b0, m_state}, {29'b0, data[2:0]});
		check_value("bg_sel", {29'b0, m_bg}, {29'b0, data[6:4]});
		check_value("map", {29'b0, m_map}, {29'b0, data[10:8]});
		// video side pins
		check_value("state pin", {29'b0, m_state}, {29'b0, state_out});
		check_value("background pin", {29'b0, m_bg}, {29'b0, background_sel});
	endtask

	task automatic check_scores();
		logic [31:0] data;
		axi_read(`REG_SCORE, game_pkg::RESP_OKAY, data);
		check_value("blue score", {24'b0, m_blue}, {24'b0, data[7:0]});
		check_value("red score", {24'b0, m_red}, {24'b0, data[15:8]});
	endtask

	task automatic begin_test(input string name);
		cur_test        = name;
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %s finished: %0d checks, %0d errors", cur_test,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	// load pulses are one cycle wide
	always @(posedge Clk)
		load_prev <= rst_n ? load_background : 1'b0;

	assert property (@(posedge Clk) disable iff (!rst_n) !(load_background && load_prev))
	else
	begin
		errors++;
		$display("load_background was high for two cycles in a row in test %s", cur_test);
	end

	always @(negedge Clk)
	begin
		if (count_loads && load_background)
			load_count++;
	end

	initial
	begin
		repeat (RESET_CYCLES + TOTAL_TRANSACTIONS * CYCLES_PER_TRANSACTION) @(posedge Clk);
		$display("watchdog expired: tests did not finish within the allowed cycles");
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		logic [31:0] data;
		logic [7:0]  code;
		int          i;

		axi_req     = '0;
		blue_win    = 1'b0;
		red_win     = 1'b0;
		errors      = 0;
		checks      = 0;
		tests_run   = 0;
		cur_test    = "reset";
		count_loads = 1'b0;
		load_count  = 0;
		rng         = 32'hae03;
		m_state     = game_pkg::ST_MENU;
		m_map       = 3'd1;
		m_bg        = game_pkg::BG_MENU;
		m_blue      = '0;
		m_red       = '0;
		m_code      = '0;
		m_bg_changes = 0;

		wait (rst_n);

		begin_test("register_access");
		check_status();
		check_scores();
		write_key(8'h3c);
		axi_read(`REG_KEYCODE, game_pkg::RESP_OKAY, data);
		check_value("keycode", 32'h3c, data);
		// no strobe, no update
		axi_write(`REG_KEYCODE, 32'h77, 4'h0, game_pkg::RESP_OKAY);
		axi_read(`REG_KEYCODE, game_pkg::RESP_OKAY, data);
		check_value("keycode strobe", 32'h3c, data);
		// both control bits set, then read back as zero
		pulse_control(1'b1, 1'b1);
		axi_read(`REG_CONTROL, game_pkg::RESP_OKAY, data);
		check_value("control", 32'h0, data);
		axi_write(8'h10, 32'hffff_ffff, 4'hf, game_pkg::RESP_SLVERR);
		axi_read(8'h10, game_pkg::RESP_SLVERR, data);
		check_value("unmapped data", 32'h0, data);
		end_test();

		begin_test("map_select");
		m_bg_changes = 0;
		load_count   = 0;
		count_loads  = 1'b1;
		for (i = 0; i < MAP_STEPS; i++)
		begin
			rng = xorshift32(rng);
			case (rng % 7)
				0:       code = game_pkg::KC_W;
				1:       code = game_pkg::KC_UP;
				2:       code = game_pkg::KC_S;
				3:       code = game_pkg::KC_DOWN;
				4:       code = 8'h00;
				5:       code = 8'h04;
				default: code = m_code;
			endcase
			write_key(code);
			check_status();
		end
		end_test();

		begin_test("blue_round");
		tap_key(game_pkg::KC_ENTER);
		check_status();
		tap_key(game_pkg::KC_ENTER);
		check_status();
		raise_win(1'b1, 1'b0);
		check_status();
		check_scores();
		tap_key(game_pkg::KC_ENTER);
		check_status();
		end_test();

		begin_test("priority_round_reset");
		enter_round();
		pulse_control(1'b0, 1'b1);
		check_status();
		tap_key(game_pkg::KC_ENTER);
		raise_win(1'b1, 1'b1);
		check_status();
		check_scores();
		tap_key(game_pkg::KC_ENTER);
		enter_round();
		raise_win(1'b0, 1'b1);
		check_status();
		check_scores();
		tap_key(game_pkg::KC_ENTER);
		check_status();
		end_test();

		begin_test("game_reset");
		// leave map 1 so the reset has a map to restore
		tap_key(game_pkg::KC_UP);
		enter_round();
		check_status();
		pulse_control(1'b1, 1'b0);
		check_status();
		check_scores();
		end_test();

		begin_test("background_load");
		@(negedge Clk);
		count_loads = 1'b0;
		check_value("load pulses", 32'(m_bg_changes), 32'(load_count));
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
